//--- common/vga_dbg_pkg.sv
package vga_dbg_pkg;

  // scan position and data widths
  typedef logic [10:0] hpos_t;     // 0..1799
  typedef logic [9:0]  vpos_t;     // 0..794
  typedef logic [5:0]  row_addr_t; // text row, sy / 16
  typedef logic [31:0] word_t;

  // one 4-bit vga channel
  typedef logic [3:0] color4_t;

  typedef struct packed {
    color4_t r;
    color4_t g;
    color4_t b;
  } rgb_t;

  // horizontal timing, 1368 active of 1800 total
  localparam hpos_t h_active_end = 11'd1367;
  localparam hpos_t h_sync_start = 11'd1439; // hsync goes low on the next clock
  localparam hpos_t h_sync_end   = 11'd1583; // last low clock
  localparam hpos_t h_line_end   = 11'd1799;

  // vertical timing, 768 active of 795 total
  localparam vpos_t v_active_end = 10'd767;
  localparam vpos_t v_sync_start = 10'd768; // first low line
  localparam vpos_t v_sync_end   = 10'd771; // vsync back high here
  localparam vpos_t v_screen_end = 10'd794;

  // text grid
  localparam int unsigned text_rows = 46;
  localparam int unsigned reg_rows  = 32; // one per register
  localparam int unsigned glyph_w   = 8;
  localparam int unsigned glyph_h   = 16;
  localparam int unsigned num_cols  = 5;
  localparam hpos_t       col_w     = 11'd256; // 32 glyphs of 8 px

  // left edge of each column
  // instr even, instr odd, reg, data even, data odd
  localparam hpos_t col_start [num_cols] = '{
    11'd16, 11'd280, 11'd552, 11'd824, 11'd1088
  };

  localparam vpos_t text_end_y = 10'd736; // 46 * 16
  localparam vpos_t reg_end_y  = 10'd512; // 32 * 16

  // palette
  localparam rgb_t color_fg    = '{r: 4'hf, g: 4'hf, b: 4'hf};
  localparam rgb_t color_bg    = '{r: 4'h5, g: 4'h3, b: 4'h7};
  localparam rgb_t color_blank = '{r: 4'h0, g: 4'h0, b: 4'h0};

endpackage

//--- rtl/vga_timing.sv
`timescale 1ns/10ps

// free running scan position for the 1800x795 frame
module vga_timing import vga_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output hpos_t sx, // pixel within line
  output vpos_t sy  // line within frame
);

  logic line_done;
  logic frame_done;

  assign line_done  = (sx == h_line_end);
  assign frame_done = (sy == v_screen_end);

  // horizontal counter
  always_ff @(posedge clk) begin
    if (rst) begin
      sx <= '0;
    end else if (line_done) begin
      sx <= '0; // wrap after back porch
    end else begin
      sx <= sx + 11'd1;
    end
  end

  // vertical counter, steps once per line
  always_ff @(posedge clk) begin
    if (rst) begin
      sy <= '0;
    end else if (line_done) begin
      if (frame_done) begin
        sy <= '0;
      end else begin
        sy <= sy + 10'd1;
      end
    end
  end

endmodule

//--- vga_ram/vga_ram.sv
`timescale 1ns/10ps

// shadow copy of the words on screen
// three write ports, one row of five words read per clock
module vga_ram import vga_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       reg_wr,
  input  logic [4:0] reg_addr,
  input  word_t      reg_data,
  input  logic       instr_wr,
  input  word_t      instr_addr, // byte address
  input  word_t      instr_data,
  input  logic       data_wr,
  input  word_t      data_addr,  // byte address
  input  word_t      data_data,
  input  row_addr_t  row,
  output word_t      instr_even,
  output word_t      instr_odd,
  output word_t      reg_word,
  output word_t      data_even,
  output word_t      data_odd
);

  // even / odd word index split, two words per text row
  word_t instr_even_mem [text_rows];
  word_t instr_odd_mem  [text_rows];
  word_t data_even_mem  [text_rows];
  word_t data_odd_mem   [text_rows];
  word_t reg_mem        [reg_rows];

  logic [29:0] instr_idx; // word index
  logic [29:0] data_idx;
  logic        instr_ok;
  logic        data_ok;

  assign instr_idx = instr_addr[31:2]; // byte offset dropped
  assign data_idx  = data_addr[31:2];
  // only 92 words fit on screen
  assign instr_ok  = (instr_idx < 30'(2 * text_rows));
  assign data_ok   = (data_idx < 30'(2 * text_rows));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < text_rows; i++) begin
        instr_even_mem[i] <= '0;
        instr_odd_mem[i]  <= '0;
        data_even_mem[i]  <= '0;
        data_odd_mem[i]   <= '0;
      end
      for (int i = 0; i < reg_rows; i++) begin
        reg_mem[i] <= '0;
      end
    end else begin
      if (reg_wr) reg_mem[reg_addr] <= reg_data;
      if (instr_wr && instr_ok) begin
        if (instr_idx[0]) instr_odd_mem[instr_idx[6:1]]  <= instr_data;
        else              instr_even_mem[instr_idx[6:1]] <= instr_data;
      end
      if (data_wr && data_ok) begin
        if (data_idx[0]) data_odd_mem[data_idx[6:1]]  <= data_data;
        else             data_even_mem[data_idx[6:1]] <= data_data;
      end
    end
  end

  // row read, one clock latency
  always_ff @(posedge clk) begin
    if (row < row_addr_t'(text_rows)) begin
      instr_even <= instr_even_mem[row];
      instr_odd  <= instr_odd_mem[row];
      data_even  <= data_even_mem[row];
      data_odd   <= data_odd_mem[row];
    end else begin // rows in vertical blanking
      instr_even <= '0;
      instr_odd  <= '0;
      data_even  <= '0;
      data_odd   <= '0;
    end
    if (row < row_addr_t'(reg_rows)) reg_word <= reg_mem[row[4:0]];
    else                             reg_word <= '0; // no register there
  end

endmodule

//--- vga_render/vga_render.sv
`timescale 1ns/10ps

// turns shadow words into binary digit glyphs
// stage 1 lines the position up with the ram read, stage 2 is the output
module vga_render import vga_dbg_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  hpos_t   sx,
  input  vpos_t   sy,
  input  word_t   instr_even,
  input  word_t   instr_odd,
  input  word_t   reg_word,
  input  word_t   data_even,
  input  word_t   data_odd,
  output logic    hsync,
  output logic    vsync,
  output color4_t r,
  output color4_t g,
  output color4_t b
);

  logic [7:0] font_one  [glyph_h];
  logic [7:0] font_zero [glyph_h];

  initial begin
    $readmemb("vga_render/glyph_one.mem", font_one);
    $readmemb("vga_render/glyph_zero.mem", font_zero);
  end

  hpos_t      sx_q; // same cycle as the ram words
  vpos_t      sy_q;
  word_t      words [num_cols];
  logic       hit;       // inside one of the five columns
  logic [2:0] col_sel;
  hpos_t      col_off;   // pixel offset within the column
  logic [4:0] glyph_idx; // 0 is msb
  logic [2:0] glyph_col;
  logic [3:0] glyph_row;
  logic       digit;
  logic [7:0] font_bits;
  logic       pix_on;
  logic       active;
  logic       bg;
  rgb_t       pix;

  always_ff @(posedge clk) begin
    if (rst) begin
      sx_q <= '0;
      sy_q <= '0;
    end else begin
      sx_q <= sx;
      sy_q <= sy;
    end
  end

  // column order matches col_start
  always_comb begin
    words[0] = instr_even;
    words[1] = instr_odd;
    words[2] = reg_word;
    words[3] = data_even;
    words[4] = data_odd;
  end

  // find the column under sx_q
  always_comb begin
    hit     = 1'b0;
    col_sel = '0;
    col_off = '0;
    for (int c = 0; c < num_cols; c++) begin
      if (sx_q >= col_start[c] && sx_q < col_start[c] + col_w) begin
        hit     = 1'b1;
        col_sel = 3'(c);
        col_off = sx_q - col_start[c];
      end
    end
  end

  assign glyph_idx = 5'(col_off / glyph_w);
  assign glyph_col = 3'(col_off % glyph_w);
  assign glyph_row = 4'(sy_q % glyph_h);
  assign digit     = words[col_sel][5'd31 - glyph_idx]; // msb on the left
  assign font_bits = digit ? font_one[glyph_row] : font_zero[glyph_row];
  assign pix_on    = font_bits[3'd7 - glyph_col]; // bit 7 is leftmost pixel

  assign active = (sx_q <= h_active_end) && (sy_q <= v_active_end);

  // gaps, rows below the text, and the register column past r31
  assign bg = !hit || (sy_q >= text_end_y) ||
              (col_sel == 3'd2 && sy_q >= reg_end_y);

  always_comb begin
    if (!active)     pix = color_blank;
    else if (bg)     pix = color_bg;
    else if (pix_on) pix = color_fg;
    else             pix = color_bg; // glyph background
  end

  // output stage, syncs negative
  always_ff @(posedge clk) begin
    if (rst) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      r     <= '0;
      g     <= '0;
      b     <= '0;
    end else begin
      hsync <= !(sx_q > h_sync_start && sx_q <= h_sync_end);
      vsync <= !(sy_q >= v_sync_start && sy_q < v_sync_end);
      r     <= pix.r;
      g     <= pix.g;
      b     <= pix.b;
    end
  end

endmodule

//--- rtl/vga_debug_top.sv
`timescale 1ns/10ps

// debug display, counter -> shadow ram -> renderer
module vga_debug_top import vga_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       reg_wr,
  input  logic [4:0] reg_addr,
  input  word_t      reg_data,
  input  logic       instr_wr,
  input  word_t      instr_addr,
  input  word_t      instr_data,
  input  logic       data_wr,
  input  word_t      data_addr,
  input  word_t      data_data,
  output logic       hsync,
  output logic       vsync,
  output color4_t    r,
  output color4_t    g,
  output color4_t    b
);

  hpos_t     sx;
  vpos_t     sy;
  row_addr_t row;
  word_t     instr_even;
  word_t     instr_odd;
  word_t     reg_word;
  word_t     data_even;
  word_t     data_odd;

  assign row = row_addr_t'(sy / glyph_h); // text row under the beam

  vga_timing timing_i (
    .clk (clk),
    .rst (rst),
    .sx  (sx),
    .sy  (sy)
  );

  vga_ram ram_i (
    .clk        (clk),
    .rst        (rst),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_data   (reg_data),
    .instr_wr   (instr_wr),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .data_wr    (data_wr),
    .data_addr  (data_addr),
    .data_data  (data_data),
    .row        (row),
    .instr_even (instr_even),
    .instr_odd  (instr_odd),
    .reg_word   (reg_word),
    .data_even  (data_even),
    .data_odd   (data_odd)
  );

  // sx/sy go in undelayed, the renderer lines them up with the ram read
  vga_render render_i (
    .clk        (clk),
    .rst        (rst),
    .sx         (sx),
    .sy         (sy),
    .instr_even (instr_even),
    .instr_odd  (instr_odd),
    .reg_word   (reg_word),
    .data_even  (data_even),
    .data_odd   (data_odd),
    .hsync      (hsync),
    .vsync      (vsync),
    .r          (r),
    .g          (g),
    .b          (b)
  );

endmodule

//--- tests/tb_vga_debug.sv
`timescale 1ns/10ps

// testbench for the debug display, replays tests/vga_testdata.txt
module tb_vga_debug import vga_dbg_pkg::*; ();

  localparam longint line_clks  = longint'(h_line_end) + 1;
  localparam longint frame_clks = line_clks * (longint'(v_screen_end) + 1);
  localparam int     port_reg   = 0;
  localparam int     port_instr = 1;
  localparam int     port_data  = 2;

  typedef logic [8*24-1:0] name_t; // test name as read by sscanf

  logic       clk;
  logic       rst;
  logic       reg_wr;
  logic [4:0] reg_addr;
  word_t      reg_data;
  logic       instr_wr;
  word_t      instr_addr;
  word_t      instr_data;
  logic       data_wr;
  word_t      data_addr;
  word_t      data_data;
  logic       hsync;
  logic       vsync;
  color4_t    r;
  color4_t    g;
  color4_t    b;

  longint edge_cnt;   // rising edges since rst fell
  longint ready_edge; // first output edge that shows the last write
  logic   st_on [3];  // staged writes, index is the port
  word_t  st_addr [3];
  word_t  st_data [3];

  vga_debug_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_data   (reg_data),
    .instr_wr   (instr_wr),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .data_wr    (data_wr),
    .data_addr  (data_addr),
    .data_data  (data_data),
    .hsync      (hsync),
    .vsync      (vsync),
    .r          (r),
    .g          (g),
    .b          (b)
  );

  always #50 clk = ~clk; // 100 ns pixel clock

  always @(posedge clk) begin
    if (rst) edge_cnt <= 0;
    else     edge_cnt <= edge_cnt + 1; // edge n shows pixel n-2
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_color(input name_t name, input color4_t er, input color4_t eg,
                             input color4_t eb, input color4_t ar, input color4_t ag,
                             input color4_t ab);
    if (ar !== er || ag !== eg || ab !== eb) begin
      $display("Mismatch %0s: rgb expected %h,%h,%h actual %h,%h,%h",
               name, er, eg, eb, ar, ag, ab);
      $display("TESTS FAILED");
      $fatal(1, "color check failed");
    end
  endtask

  // {hsync, vsync}
  task automatic check_sync(input name_t name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("Mismatch %0s: hs/vs expected %b actual %b", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "sync check failed");
    end
  endtask

  // one strobe cycle for everything staged
  task automatic pulse_writes;
    if (st_on[port_reg] || st_on[port_instr] || st_on[port_data]) begin
      @(posedge clk);
      #1;
      reg_wr     = st_on[port_reg];
      reg_addr   = st_addr[port_reg][4:0];
      reg_data   = st_data[port_reg];
      instr_wr   = st_on[port_instr];
      instr_addr = st_addr[port_instr];
      instr_data = st_data[port_instr];
      data_wr    = st_on[port_data];
      data_addr  = st_addr[port_data];
      data_data  = st_data[port_data];
      @(posedge clk);
      #1;
      reg_wr   = 1'b0;
      instr_wr = 1'b0;
      data_wr  = 1'b0;
      for (int i = 0; i < 3; i++) st_on[i] = 1'b0;
      ready_edge = edge_cnt + 2; // ram read then output stage
    end
  endtask

  // a port already staged closes the group
  task automatic stage_write(input int port, input word_t addr, input word_t wdata);
    if (st_on[port]) pulse_writes();
    st_on[port]   = 1'b1;
    st_addr[port] = addr;
    st_data[port] = wdata;
  endtask

  // random words into rows that no sample looks at
  task automatic fill_rows;
    for (int i = 0; i < 8; i++) begin
      stage_write(port_reg, word_t'(20 + i), $urandom());
      stage_write(port_instr, word_t'((60 + i) * 4), $urandom()); // rows 30..33
      stage_write(port_data, word_t'((70 + i) * 4), $urandom());  // rows 35..38
      pulse_writes();
    end
  endtask

  task automatic wait_for_pixel(input int x, input int y);
    longint waited;
    longint pix;
    longint target;
    logic   found;
    found  = 1'b0;
    target = longint'(y) * line_clks + longint'(x);
    for (waited = 0; waited < 2 * frame_clks && !found; waited++) begin
      @(negedge clk); // outputs settled
      if (edge_cnt >= 2 && edge_cnt >= ready_edge) begin
        pix = (edge_cnt - 2) % frame_clks;
        if (pix == target) found = 1'b1;
      end
    end
    if (!found) stop_run($sformatf("timed out waiting for pixel x %0d y %0d", x, y));
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [63:0] port;
    word_t       addr;
    word_t       wdata;
    name_t       name;
    int          x;
    int          y;
    color4_t     er;
    color4_t     eg;
    color4_t     eb;
    logic        ehs;
    logic        evs;

    clk        = 1'b0;
    rst        = 1'b1;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_data   = '0;
    instr_wr   = 1'b0;
    instr_addr = '0;
    instr_data = '0;
    data_wr    = 1'b0;
    data_addr  = '0;
    data_data  = '0;
    ready_edge = 0;
    for (int i = 0; i < 3; i++) begin
      st_on[i]   = 1'b0;
      st_addr[i] = '0;
      st_data[i] = '0;
    end
    void'($urandom(75)); // filler data seed

    // four reset edges, outputs checked before release
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_sync(name_t'("reset"), 2'b11, {hsync, vsync});
    check_color(name_t'("reset"), 4'h0, 4'h0, 4'h0, r, g, b);
    @(posedge clk);
    #1;
    rst = 1'b0;

    fill_rows();

    // data word 129 is off screen, its low index bits alias row 0 odd
    stage_write(port_data, word_t'(129 * 4), 32'hffff_ffff);
    pulse_writes();

    fd = $fopen("tests/vga_testdata.txt", "r");
    if (fd == 0) stop_run("could not open the test data file tests/vga_testdata.txt");
    while ($fgets(line, fd) != 0) begin
      kind = line.getc(0);
      if (line.len() < 2 || kind == "#") continue; // comment or blank
      if (kind == "W") begin
        n = $sscanf(line, "W %s %h %h", port, addr, wdata);
        if (n != 3) stop_run($sformatf("bad write line in test data: %s", line));
        if (port == 64'("reg"))        stage_write(port_reg, addr, wdata);
        else if (port == 64'("instr")) stage_write(port_instr, addr, wdata);
        else if (port == 64'("data"))  stage_write(port_data, addr, wdata);
        else stop_run($sformatf("unknown write port in test data: %s", line));
      end else if (kind == "S") begin
        n = $sscanf(line, "S %s %d %d %h %h %h %b %b", name, x, y, er, eg, eb, ehs, evs);
        if (n != 8) stop_run($sformatf("bad sample line in test data: %s", line));
        pulse_writes(); // pending writes land first
        wait_for_pixel(x, y);
        check_color(name, er, eg, eb, r, g, b);
        check_sync(name, {ehs, evs}, {hsync, vsync});
      end else begin
        stop_run($sformatf("unknown line in test data: %s", line));
      end
    end
    $fclose(fd);
    pulse_writes();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- vga_render/glyph_one.mem
00000000
00000000
00011000
00111000
01111000
00011000
00011000
00011000
00011000
00011000
00011000
00011000
01111110
00000000
00000000
00000000

//--- vga_render/glyph_zero.mem
00000000
00000000
00111100
01100110
01100110
01101110
01110110
01100110
01100110
01100110
01100110
00111100
00000000
00000000
00000000
00000000

//--- tests/vga_testdata.txt
# W port addr data : write on port reg, instr or data, addr and data in hex
# S name x y r g b hs vs : pixel sample, x y decimal, colors hex, syncs binary
S clr_ie 17 3 f f f 1 1
S clr_io 290 3 f f f 1 1
S clr_reg 557 3 f f f 1 1
S clr_de 827 3 5 3 7 1 1
S clr_do 1094 3 f f f 1 1
S hs_pre 1439 3 0 0 0 1 1
S hs_first 1440 3 0 0 0 0 1
S hs_last 1583 3 0 0 0 0 1
S hs_post 1584 3 0 0 0 1 1
S gap_left 8 20 5 3 7 1 1
S gap_right 1350 20 5 3 7 1 1
S reg_cut 557 515 5 3 7 1 1
S below_text 100 740 5 3 7 1 1
S blank_x 1368 767 0 0 0 1 1
S vs_first 0 768 0 0 0 1 0
S vs_last 0 770 0 0 0 1 0
S vs_post 0 771 0 0 0 1 1
W reg 3 80000001
W instr 28 ffffffff
W data 2a 80000000
W instr 2f 00000001
W data 2d 00010000
W instr 200 ffffffff
W data 170 ffffffff
W instr 38 0000000f
W reg 7 f0000000
W data 3c 00000100
S ign_ie 19 12 5 3 7 1 1
S r3_g0 553 60 f f f 1 1
S r3_g15 673 60 5 3 7 1 1
S r3_g31 801 60 f f f 1 1
S r5_ie 99 92 f f f 1 1
S r5_io_g31 531 92 f f f 1 1
S r5_de_g0 827 92 f f f 1 1
S r5_de_g1 835 92 5 3 7 1 1
S r5_do_g15 1211 92 f f f 1 1
S r7_ie_g28 243 124 f f f 1 1
S r7_reg_g3 579 124 f f f 1 1
S r7_do_g23 1275 124 f f f 1 1

//--- tb.f
common/vga_dbg_pkg.sv
rtl/vga_timing.sv
vga_ram/vga_ram.sv
vga_render/vga_render.sv
rtl/vga_debug_top.sv
tests/tb_vga_debug.sv

//--- Makefile
# build and run from the project root so the data and font paths resolve

sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_vga_debug -o tb_vga_debug
	./obj_dir/tb_vga_debug

clean:
	rm -rf obj_dir
